// File: des_core.f
src/des_pkg.sv
src/des_sbox.sv
src/des_feistel.sv
src/des_key_schedule.sv
src/des_core.sv
tests/des_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the DES core testbench with Verilator, run it and judge the log
LOG=sim.log
verilator --binary --timing --assert -f des_core.f --top-module des_core_tb \
	-Mdir obj_dir -o des_core_sim > "$LOG" 2>&1 &&
	./obj_dir/des_core_sim >> "$LOG" 2>&1 ||
	{ echo "Build or simulation error, see $LOG"; exit 1; }
grep -q "CHECKS FAILED" "$LOG" && { echo "Simulation failed, see $LOG"; exit 1; }
grep -q "ALL CHECKS PASSED" "$LOG" ||
	{ echo "Simulation ended without a result, see $LOG"; exit 1; }
echo "Simulation passed"
exit 0

// File: tests/des_core_tb.sv
`timescale 1ns/1ns

module des_core_tb import des_pkg::*; ();

	localparam int N_VECTORS   = 6;
	localparam int N_RANDOM    = 8;
	localparam int CLK_PERIOD  = 20;
	localparam int WATCHDOG_NS = (N_VECTORS + 2 * N_RANDOM) * 20 * CLK_PERIOD * 2;

	typedef struct packed {
		logic       decrypt;
		des_block_t key;
		des_block_t block;
		des_block_t expected;
	} vector_t;

	logic       clk;
	logic       rst;
	logic       start;
	logic       decrypt;
	des_block_t data_in;
	des_block_t key;
	des_block_t data_out;
	logic       busy;
	logic       done;

	vector_t vectors [N_VECTORS];
	string   names [N_VECTORS];
	int      errors;
	int      checks;
	integer  seed;

	des_core UUT (
		.clk     (clk),
		.rst     (rst),
		.start   (start),
		.decrypt (decrypt),
		.data_in (data_in),
		.key     (key),
		.data_out(data_out),
		.busy    (busy),
		.done    (done)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout after %0d ns: done never arrived", WATCHDOG_NS);
		$display("CHECKS FAILED");
		$finish;
	end

	task automatic check(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("** Error: %s expected %h actual %h", name, expected, actual);
		end
	endtask

	// Holds reset for two cycles, then checks the idle outputs
	task automatic reset_and_check(input string name);
		rst = 1'b1;
		repeat (2) @(posedge clk);
		#2;
		rst = 1'b0;
		check({name, " busy"}, 64'(1'b0), 64'(busy));
		check({name, " done"}, 64'(1'b0), 64'(done));
		check({name, " data_out"}, 64'h0, data_out);
	endtask

	// Published single DES vectors, each run forward and back
	task automatic fill_vectors();
		names[0]   = "enc 133457799BBCDFF1";
		vectors[0] = '{1'b0, 64'h1334_5779_9BBC_DFF1, 64'h0123_4567_89AB_CDEF,
			64'h85E8_1354_0F0A_B405};
		names[1]   = "enc 0E329232EA6D0D73";
		vectors[1] = '{1'b0, 64'h0E32_9232_EA6D_0D73, 64'h8787_8787_8787_8787,
			64'h0000_0000_0000_0000};
		names[2]   = "enc all zero";
		vectors[2] = '{1'b0, 64'h0000_0000_0000_0000, 64'h0000_0000_0000_0000,
			64'h8CA6_4DE9_C1B1_23A7};
		names[3]   = "dec 133457799BBCDFF1";
		vectors[3] = '{1'b1, 64'h1334_5779_9BBC_DFF1, 64'h85E8_1354_0F0A_B405,
			64'h0123_4567_89AB_CDEF};
		names[4]   = "dec 0E329232EA6D0D73";
		vectors[4] = '{1'b1, 64'h0E32_9232_EA6D_0D73, 64'h0000_0000_0000_0000,
			64'h8787_8787_8787_8787};
		names[5]   = "dec all zero";
		vectors[5] = '{1'b1, 64'h0000_0000_0000_0000, 64'h8CA6_4DE9_C1B1_23A7,
			64'h0000_0000_0000_0000};
	endtask

	// Runs one block and checks busy, latency and the done pulse on the way.
	// A non-negative intrude_at pulses start with other data after that many rounds
	task automatic run_block(input string name, input logic dec, input des_block_t k,
		input des_block_t blk, input int intrude_at, output des_block_t result);
		int cycles;
		cycles  = 0;
		decrypt = dec;
		key     = k;
		data_in = blk;
		start   = 1'b1;
		@(posedge clk);
		#2;
		start = 1'b0;
		while (done !== 1'b1) begin
			check({name, " busy"}, 64'(1'b1), 64'(busy));
			if (cycles == intrude_at) begin
				start   = 1'b1;
				decrypt = ~dec;
				key     = ~k;
				data_in = ~blk;
			end else begin
				start = 1'b0;
			end
			@(posedge clk);
			#2;
			cycles++;
		end
		start = 1'b0;
		check({name, " latency"}, 64'(DES_ROUNDS), 64'(cycles));
		check({name, " busy after done"}, 64'(1'b0), 64'(busy));
		result = data_out;
		@(posedge clk);
		#2;
		check({name, " done width"}, 64'(1'b0), 64'(done));
		check({name, " held output"}, result, data_out);
	endtask

	initial begin
		des_block_t result;
		des_block_t plain;
		des_block_t cipher;
		des_block_t rkey;
		rst     = 1'b1;
		start   = 1'b0;
		decrypt = 1'b0;
		data_in = '0;
		key     = '0;
		errors  = 0;
		checks  = 0;
		seed    = 32'h7e95_68a3;
		fill_vectors();
		reset_and_check("reset");

		for (int i = 0; i < N_VECTORS; i++) begin
			run_block(names[i], vectors[i].decrypt, vectors[i].key, vectors[i].block, -1,
				result);
			check(names[i], vectors[i].expected, result);
		end

		for (int i = 0; i < N_RANDOM; i++) begin
			rkey  = {$random(seed), $random(seed)};
			plain = {$random(seed), $random(seed)};
			run_block("random encrypt", 1'b0, rkey, plain, -1, cipher);
			run_block("random decrypt", 1'b1, rkey, cipher, -1, result);
			check("random round trip", plain, result);
		end

		// The second start lands after round 5 and must leave no trace
		run_block("start while busy", vectors[0].decrypt, vectors[0].key, vectors[0].block,
			5, result);
		check("start while busy", vectors[0].expected, result);
		repeat (DES_ROUNDS + 4) begin
			@(posedge clk);
			#2;
			check("no extra done", 64'(1'b0), 64'(done));
		end

		// A reset in the middle of a run clears the held result and stops the run
		decrypt = vectors[0].decrypt;
		key     = vectors[0].key;
		data_in = vectors[0].block;
		start   = 1'b1;
		@(posedge clk);
		#2;
		start = 1'b0;
		repeat (4) @(posedge clk);
		#2;
		reset_and_check("reset mid-run");

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: src/des_core.sv
`timescale 1ns/1ns

module des_core import des_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       start,
	input  logic       decrypt,
	input  des_block_t data_in,
	input  des_block_t key,
	output des_block_t data_out,
	output logic       busy,
	output logic       done
);

	des_state_t  state;
	round_t      round;
	des_lr_t     lr;
	des_block_t  ip_bits;
	des_block_t  preout;
	des_block_t  fp_bits;
	des_subkey_t subkey;
	des_half_t   f_out;
	des_half_t   r_next;
	logic        load;
	logic        step;
	logic        last;

	assign load = start && (state == IDLE);
	assign step = (state == RUN);
	assign last = step && (round == round_t'(DES_ROUNDS));
	assign busy = (state == RUN);

	always_comb begin
		for (int i = 0; i < 64; i++) begin
			ip_bits[i] = data_in[IP_TABLE[i] - 1];
		end
	end

	des_key_schedule u_key_schedule (
		.clk    (clk),
		.rst    (rst),
		.load   (load),
		.step   (step),
		.decrypt(decrypt),
		.key    (key),
		.round  (round),
		.subkey (subkey)
	);

	des_feistel u_feistel (
		.r     (lr.r),
		.subkey(subkey),
		.f_out (f_out)
	);

	assign r_next = lr.l ^ f_out;

	// The last round is taken straight into the output with the halves swapped
	assign preout = {r_next, lr.r};

	always_comb begin
		for (int i = 0; i < 64; i++) begin
			fp_bits[i] = preout[FP_TABLE[i] - 1];
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			lr <= des_lr_t'(ip_bits);
		end else if (step) begin
			lr <= '{l: lr.r, r: r_next};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= IDLE;
			round    <= '0;
			done     <= 1'b0;
			data_out <= '0;
		end else begin
			done <= last;
			if (last) begin
				data_out <= fp_bits;
			end
			case (state)
				IDLE: begin
					if (start) begin
						state <= RUN;
						round <= round_t'(1);
					end
				end
				RUN: begin
					if (last) begin
						state <= IDLE;
						round <= '0;
					end else begin
						round <= round + round_t'(1);
					end
				end
				default: begin
					state <= IDLE;
					round <= '0;
				end
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (rst) done |=> !done);

	assert property (@(posedge clk) disable iff (rst) round <= round_t'(DES_ROUNDS));

	assert property (@(posedge clk) disable iff (rst) !(busy && done));

endmodule

// File: src/des_key_schedule.sv
`timescale 1ns/1ns

module des_key_schedule import des_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        load,
	input  logic        step,
	input  logic        decrypt,
	input  des_block_t  key,
	input  round_t      round,
	output des_subkey_t subkey
);

	des_cd_t     cd;
	des_cd_t     cd_next;
	des_cd_t     key_src;
	logic [0:55] pc1_bits;
	logic [0:55] src_bits;
	logic        dec_q;
	logic [3:0]  enc_idx;
	logic [3:0]  dec_idx;

	function automatic des_key_half_t rotl(des_key_half_t v, int n);
		if (n == 2) begin
			return {v[2:27], v[0:1]};
		end
		return {v[1:27], v[0]};
	endfunction

	function automatic des_key_half_t rotr(des_key_half_t v, int n);
		if (n == 2) begin
			return {v[26:27], v[0:25]};
		end
		return {v[27], v[0:26]};
	endfunction

	always_comb begin
		for (int i = 0; i < 56; i++) begin
			pc1_bits[i] = key[PC1_TABLE[i] - 1];
		end
	end

	// Decrypt walks back through the mirrored round's shift
	assign enc_idx = 4'(round - round_t'(1));
	assign dec_idx = 4'(round_t'(DES_ROUNDS) - round);

	always_comb begin
		if (dec_q) begin
			cd_next.c = rotr(cd.c, SHIFT_TABLE[dec_idx]);
			cd_next.d = rotr(cd.d, SHIFT_TABLE[dec_idx]);
		end else begin
			cd_next.c = rotl(cd.c, SHIFT_TABLE[enc_idx]);
			cd_next.d = rotl(cd.d, SHIFT_TABLE[enc_idx]);
		end
	end

	// Encrypt rotates before use, decrypt uses the register and rotates after
	assign key_src  = dec_q ? cd : cd_next;
	assign src_bits = key_src;

	always_comb begin
		for (int i = 0; i < 48; i++) begin
			subkey[i] = src_bits[PC2_TABLE[i] - 1];
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			cd <= des_cd_t'(pc1_bits);
		end else if (step) begin
			cd <= cd_next;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			dec_q <= 1'b0;
		end else if (load) begin
			dec_q <= decrypt;
		end
	end

	// Sixteen rounds rotate each half by 28 in total
	assert property (@(posedge clk) disable iff (rst)
		step && round == round_t'(DES_ROUNDS) |=> cd == $past(cd, DES_ROUNDS));

endmodule

// File: src/des_feistel.sv
`timescale 1ns/1ns

module des_feistel import des_pkg::*; (
	input  des_half_t   r,
	input  des_subkey_t subkey,
	output des_half_t   f_out
);

	des_subkey_t expanded;
	des_subkey_t mixed;
	des_half_t   sbox_bits;

	always_comb begin
		for (int i = 0; i < 48; i++) begin
			expanded[i] = r[E_TABLE[i] - 1];
		end
	end

	assign mixed = expanded ^ subkey;

	// Slice b of the mixed word feeds box b+1
	for (genvar b = 0; b < 8; b++) begin : g_sbox
		des_sbox #(
			.BOX(b + 1)
		) u_sbox (
			.din (mixed[6*b +: 6]),
			.dout(sbox_bits[4*b +: 4])
		);
	end

	always_comb begin
		for (int i = 0; i < 32; i++) begin
			f_out[i] = sbox_bits[P_TABLE[i] - 1];
		end
	end

endmodule

// File: src/des_sbox.sv
`timescale 1ns/1ns

module des_sbox import des_pkg::*; #(
	parameter int BOX = 1
) (
	input  sbox_in_t  din,
	output sbox_out_t dout
);

	logic [1:0] row;
	logic [3:0] col;
	logic [5:0] entry;

	// Outer bits pick the row, inner four bits pick the column
	assign row   = {din[0], din[5]};
	assign col   = din[1:4];
	assign entry = {row, col};

	always_comb begin
		dout = sbox_out_t'(SBOX_TABLE[BOX - 1][entry]);
	end

endmodule

// File: src/des_pkg.sv
package des_pkg;

	localparam int DES_ROUNDS = 16;

	// Bit 0 is the leftmost bit, matching the standard's MSB-first numbering
	typedef logic [0:63] des_block_t;
	typedef logic [0:31] des_half_t;
	typedef logic [0:27] des_key_half_t;
	typedef logic [0:47] des_subkey_t;
	typedef logic [0:5]  sbox_in_t;
	typedef logic [0:3]  sbox_out_t;
	typedef logic [4:0]  round_t;

	typedef enum logic {
		IDLE,
		RUN
	} des_state_t;

	typedef struct packed {
		des_half_t l;
		des_half_t r;
	} des_lr_t;

	typedef struct packed {
		des_key_half_t c;
		des_key_half_t d;
	} des_cd_t;

	// Entries give the 1-based source bit for each output bit
	localparam int IP_TABLE [64] = '{
		58, 50, 42, 34, 26, 18, 10,  2,
		60, 52, 44, 36, 28, 20, 12,  4,
		62, 54, 46, 38, 30, 22, 14,  6,
		64, 56, 48, 40, 32, 24, 16,  8,
		57, 49, 41, 33, 25, 17,  9,  1,
		59, 51, 43, 35, 27, 19, 11,  3,
		61, 53, 45, 37, 29, 21, 13,  5,
		63, 55, 47, 39, 31, 23, 15,  7
	};

	localparam int FP_TABLE [64] = '{
		40,  8, 48, 16, 56, 24, 64, 32,
		39,  7, 47, 15, 55, 23, 63, 31,
		38,  6, 46, 14, 54, 22, 62, 30,
		37,  5, 45, 13, 53, 21, 61, 29,
		36,  4, 44, 12, 52, 20, 60, 28,
		35,  3, 43, 11, 51, 19, 59, 27,
		34,  2, 42, 10, 50, 18, 58, 26,
		33,  1, 41,  9, 49, 17, 57, 25
	};

	localparam int E_TABLE [48] = '{
		32,  1,  2,  3,  4,  5,
		 4,  5,  6,  7,  8,  9,
		 8,  9, 10, 11, 12, 13,
		12, 13, 14, 15, 16, 17,
		16, 17, 18, 19, 20, 21,
		20, 21, 22, 23, 24, 25,
		24, 25, 26, 27, 28, 29,
		28, 29, 30, 31, 32,  1
	};

	localparam int P_TABLE [32] = '{
		16,  7, 20, 21, 29, 12, 28, 17,
		 1, 15, 23, 26,  5, 18, 31, 10,
		 2,  8, 24, 14, 32, 27,  3,  9,
		19, 13, 30,  6, 22, 11,  4, 25
	};

	localparam int PC1_TABLE [56] = '{
		57, 49, 41, 33, 25, 17,  9,
		 1, 58, 50, 42, 34, 26, 18,
		10,  2, 59, 51, 43, 35, 27,
		19, 11,  3, 60, 52, 44, 36,
		63, 55, 47, 39, 31, 23, 15,
		 7, 62, 54, 46, 38, 30, 22,
		14,  6, 61, 53, 45, 37, 29,
		21, 13,  5, 28, 20, 12,  4
	};

	localparam int PC2_TABLE [48] = '{
		14, 17, 11, 24,  1,  5,
		 3, 28, 15,  6, 21, 10,
		23, 19, 12,  4, 26,  8,
		16,  7, 27, 20, 13,  2,
		41, 52, 31, 37, 47, 55,
		30, 40, 51, 45, 33, 48,
		44, 49, 39, 56, 34, 53,
		46, 42, 50, 36, 29, 32
	};

	localparam int SHIFT_TABLE [16] = '{
		1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1
	};

	// Each box is four rows of sixteen columns, row major
	localparam int SBOX_TABLE [8][64] = '{
		'{
			14,  4, 13,  1,  2, 15, 11,  8,  3, 10,  6, 12,  5,  9,  0,  7,
			 0, 15,  7,  4, 14,  2, 13,  1, 10,  6, 12, 11,  9,  5,  3,  8,
			 4,  1, 14,  8, 13,  6,  2, 11, 15, 12,  9,  7,  3, 10,  5,  0,
			15, 12,  8,  2,  4,  9,  1,  7,  5, 11,  3, 14, 10,  0,  6, 13
		},
		'{
			15,  1,  8, 14,  6, 11,  3,  4,  9,  7,  2, 13, 12,  0,  5, 10,
			 3, 13,  4,  7, 15,  2,  8, 14, 12,  0,  1, 10,  6,  9, 11,  5,
			 0, 14,  7, 11, 10,  4, 13,  1,  5,  8, 12,  6,  9,  3,  2, 15,
			13,  8, 10,  1,  3, 15,  4,  2, 11,  6,  7, 12,  0,  5, 14,  9
		},
		'{
			10,  0,  9, 14,  6,  3, 15,  5,  1, 13, 12,  7, 11,  4,  2,  8,
			13,  7,  0,  9,  3,  4,  6, 10,  2,  8,  5, 14, 12, 11, 15,  1,
			13,  6,  4,  9,  8, 15,  3,  0, 11,  1,  2, 12,  5, 10, 14,  7,
			 1, 10, 13,  0,  6,  9,  8,  7,  4, 15, 14,  3, 11,  5,  2, 12
		},
		'{
			 7, 13, 14,  3,  0,  6,  9, 10,  1,  2,  8,  5, 11, 12,  4, 15,
			13,  8, 11,  5,  6, 15,  0,  3,  4,  7,  2, 12,  1, 10, 14,  9,
			10,  6,  9,  0, 12, 11,  7, 13, 15,  1,  3, 14,  5,  2,  8,  4,
			 3, 15,  0,  6, 10,  1, 13,  8,  9,  4,  5, 11, 12,  7,  2, 14
		},
		'{
			 2, 12,  4,  1,  7, 10, 11,  6,  8,  5,  3, 15, 13,  0, 14,  9,
			14, 11,  2, 12,  4,  7, 13,  1,  5,  0, 15, 10,  3,  9,  8,  6,
			 4,  2,  1, 11, 10, 13,  7,  8, 15,  9, 12,  5,  6,  3,  0, 14,
			11,  8, 12,  7,  1, 14,  2, 13,  6, 15,  0,  9, 10,  4,  5,  3
		},
		'{
			12,  1, 10, 15,  9,  2,  6,  8,  0, 13,  3,  4, 14,  7,  5, 11,
			10, 15,  4,  2,  7, 12,  9,  5,  6,  1, 13, 14,  0, 11,  3,  8,
			 9, 14, 15,  5,  2,  8, 12,  3,  7,  0,  4, 10,  1, 13, 11,  6,
			 4,  3,  2, 12,  9,  5, 15, 10, 11, 14,  1,  7,  6,  0,  8, 13
		},
		'{
			 4, 11,  2, 14, 15,  0,  8, 13,  3, 12,  9,  7,  5, 10,  6,  1,
			13,  0, 11,  7,  4,  9,  1, 10, 14,  3,  5, 12,  2, 15,  8,  6,
			 1,  4, 11, 13, 12,  3,  7, 14, 10, 15,  6,  8,  0,  5,  9,  2,
			 6, 11, 13,  8,  1,  4, 10,  7,  9,  5,  0, 15, 14,  2,  3, 12
		},
		'{
			13,  2,  8,  4,  6, 15, 11,  1, 10,  9,  3, 14,  5,  0, 12,  7,
			 1, 15, 13,  8, 10,  3,  7,  4, 12,  5,  6, 11,  0, 14,  9,  2,
			 7, 11,  4,  1,  9, 12, 14,  2,  0,  6, 10, 13, 15,  3,  5,  8,
			 2,  1, 14,  7,  4, 10,  8, 13, 15, 12,  9,  0,  3,  5,  6, 11
		}
	};

endpackage
